// ==== list.f ====
verilog/arch_pkg.sv
verilog/rob_pkg.sv
verilog/rob.sv
verilog/reg_file.sv
verilog/redirect_port.sv
verilog/rob_top.sv
tests/rob_tb.sv

// ==== run.sh ====
#!/bin/bash
# build the rob testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -f list.f --top-module rob_tb -o rob_sim \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/rob_sim > sim.log 2>&1
cat sim.log
grep -q "ERRORS FOUND" sim.log && { echo "simulation failed"; exit 1; }
grep -q "NO ERRORS" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== tests/rob_tb.sv ====
module rob_tb
    import arch_pkg::*, rob_pkg::*;
();

    localparam int ROB_DEPTH    = 8;
    localparam int RESET_CYCLES = 16;
    // the longest test runs about 25 cycles, so 40 per test leaves margin
    localparam int MAX_CYCLES   = RESET_CYCLES + 6 * 40;

    logic          clk;
    logic          reset;
    issue_t        issue;
    nick_t         nick;
    logic          full;
    result_t       ex_result;
    result_t       slb_result;
    store_commit_t store_commit;
    regnm_t        rs1;
    regnm_t        rs2;
    data_t         rs1_data;
    data_t         rs2_data;
    logic          rs1_busy;
    logic          rs2_busy;
    nick_t         rs1_nick;
    nick_t         rs2_nick;
    logic          req;
    addr_t         pc;
    logic          ack;

    // reference model of the register file
    data_t  exp_data [NREGS];
    logic   exp_busy [NREGS];
    nick_t  exp_nick [NREGS];
    // what each rob entry writes when it retires
    regnm_t ent_rd   [32];
    data_t  ent_data [32];
    int     alloc_count;
    string  test_name;
    int     cycles;

    rob_top #(
        .ROB_DEPTH (ROB_DEPTH)
    ) dut_i (
        .clk          (clk),
        .reset        (reset),
        .issue        (issue),
        .nick         (nick),
        .full         (full),
        .ex_result    (ex_result),
        .slb_result   (slb_result),
        .store_commit (store_commit),
        .rs1          (rs1),
        .rs2          (rs2),
        .rs1_data     (rs1_data),
        .rs1_busy     (rs1_busy),
        .rs1_nick     (rs1_nick),
        .rs2_data     (rs2_data),
        .rs2_busy     (rs2_busy),
        .rs2_nick     (rs2_nick),
        .req          (req),
        .pc           (pc),
        .ack          (ack)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles in %s, the DUT stopped responding",
                     cycles, test_name);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    end

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("error in %s: %s expected %0h actual %0h",
                     test_name, what, expected, actual);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond === 1'b1) else begin
            $display("failure in %s: %s", test_name, what);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    // one clock edge with the current inputs, then drop the pulses
    task automatic step_clock();
        @(posedge clk);
        #2;
        issue.valid      = 1'b0;
        ex_result.valid  = 1'b0;
        slb_result.valid = 1'b0;
    endtask

    // rs2 probes the neighbouring register so the two ports see different names
    task automatic check_reg(input regnm_t r);
        regnm_t other;
        other = r ^ 5'd1;
        rs1   = r;
        rs2   = other;
        #1;
        check_value($sformatf("x%0d rs1 data", r), exp_data[r], rs1_data);
        check_value($sformatf("x%0d rs2 data", other), exp_data[other], rs2_data);
        check_value($sformatf("x%0d rs1 busy", r), 32'(exp_busy[r]), 32'(rs1_busy));
        check_value($sformatf("x%0d rs2 busy", other), 32'(exp_busy[other]), 32'(rs2_busy));
        if (exp_busy[r]) begin
            check_value($sformatf("x%0d rs1 nick", r), 32'(exp_nick[r]), 32'(rs1_nick));
        end
        if (exp_busy[other]) begin
            check_value($sformatf("x%0d rs2 nick", other), 32'(exp_nick[other]),
                        32'(rs2_nick));
        end
    endtask

    // tags are handed out in order and wrap at the depth
    task automatic drive_issue(input regnm_t rd, input logic is_store, input logic is_branch,
                               input logic pred);
        nick_t expected;
        expected        = nick_t'(alloc_count % ROB_DEPTH);
        issue.valid      = 1'b1;
        issue.rd         = rd;
        issue.is_store   = is_store;
        issue.is_branch  = is_branch;
        issue.pred_taken = pred;
        check_value("full before issue", 32'd0, 32'(full));
        check_value("issue nick", 32'(expected), 32'(nick));
        alloc_count++;
        ent_rd[expected] = is_store ? regnm_t'(0) : rd;
        if (!is_store && rd != 5'd0) begin
            exp_busy[rd] = 1'b1;
            exp_nick[rd] = expected;
        end
    endtask

    task automatic drive_result(input logic on_slb, input nick_t n, input data_t d,
                                input logic taken, input addr_t target);
        result_t r;
        r.valid     = 1'b1;
        r.nick      = n;
        r.data      = d;
        r.taken     = taken;
        r.target    = target;
        ent_data[n] = d;
        if (on_slb) begin
            slb_result = r;
        end else begin
            ex_result = r;
        end
    endtask

    // the newest producer of a register releases it
    task automatic retire_in_model(input nick_t n);
        if (ent_rd[n] != 5'd0) begin
            exp_data[ent_rd[n]] = ent_data[n];
            if (exp_nick[ent_rd[n]] == n) begin
                exp_busy[ent_rd[n]] = 1'b0;
            end
        end
    endtask

    task automatic issue_in_order();
        test_name = "issue in order";
        check_value("full after reset", 32'd0, 32'(full));
        check_value("store commit after reset", 32'd0, 32'(store_commit.valid));
        check_value("req after reset", 32'd0, 32'(req));
        check_reg(5'd31);
        drive_issue(5'd1, 1'b0, 1'b0, 1'b0);
        step_clock();
        check_reg(5'd1);
        drive_issue(5'd2, 1'b0, 1'b0, 1'b0);
        step_clock();
        check_reg(5'd2);
        drive_issue(5'd3, 1'b0, 1'b0, 1'b0);
        step_clock();
        check_reg(5'd3);
        // x0 gets an entry but never a tag
        drive_issue(5'd0, 1'b0, 1'b0, 1'b0);
        step_clock();
        check_reg(5'd0);
    endtask

    task automatic complete_out_of_order();
        test_name = "complete out of order";
        drive_result(1'b0, 5'd2, $urandom(), 1'b0, '0);
        step_clock();
        // head not done, so nothing may retire yet
        drive_result(1'b0, 5'd0, $urandom(), 1'b0, '0);
        check_reg(5'd1);
        check_reg(5'd2);
        check_reg(5'd3);
        step_clock();
        drive_result(1'b1, 5'd1, $urandom(), 1'b0, '0);
        drive_result(1'b0, 5'd3, $urandom(), 1'b0, '0);
        check_reg(5'd1);
        step_clock();
        retire_in_model(5'd0);
        check_reg(5'd1);
        check_reg(5'd2);
        step_clock();
        retire_in_model(5'd1);
        check_reg(5'd2);
        check_reg(5'd3);
        step_clock();
        retire_in_model(5'd2);
        check_reg(5'd3);
        step_clock();
        retire_in_model(5'd3);
        check_reg(5'd0);
        check_value("store commit on alu retire", 32'd0, 32'(store_commit.valid));
    endtask

    task automatic fill_to_capacity();
        nick_t base;
        test_name = "fill to capacity";
        base      = nick_t'(alloc_count % ROB_DEPTH);
        for (int i = 0; i < ROB_DEPTH; i++) begin
            drive_issue(regnm_t'(4 + i), 1'b0, 1'b0, 1'b0);
            step_clock();
        end
        // this issue must be refused
        issue.valid = 1'b1;
        issue.rd    = 5'd12;
        check_value("full at capacity", 32'd1, 32'(full));
        step_clock();
        check_value("nick after refused issue", 32'(base), 32'(nick));
        check_reg(5'd12);
        drive_result(1'b0, base, $urandom(), 1'b0, '0);
        step_clock();
        check_value("full while head retires", 32'd1, 32'(full));
        step_clock();
        retire_in_model(base);
        drive_issue(5'd12, 1'b0, 1'b0, 1'b0);
        check_reg(regnm_t'(4));
        step_clock();
        for (int i = 1; i <= ROB_DEPTH; i++) begin
            drive_result(1'b0, nick_t'((base + i) % ROB_DEPTH), $urandom(), 1'b0, '0);
            step_clock();
        end
        step_clock();
        for (int i = 1; i <= ROB_DEPTH; i++) begin
            retire_in_model(nick_t'((base + i) % ROB_DEPTH));
        end
        for (int r = 4; r <= 12; r++) begin
            check_reg(regnm_t'(r));
        end
    endtask

    task automatic retire_store();
        nick_t store_nick;
        test_name  = "retire store";
        store_nick = nick_t'(alloc_count % ROB_DEPTH);
        drive_issue(5'd13, 1'b1, 1'b0, 1'b0);
        step_clock();
        check_value("store commit valid", 32'd1, 32'(store_commit.valid));
        check_value("store commit nick", 32'(store_nick), 32'(store_commit.nick));
        step_clock();
        check_value("store commit after retire", 32'd0, 32'(store_commit.valid));
        check_reg(5'd13);
    endtask

    task automatic recover_mispredict();
        nick_t branch_nick;
        nick_t young_nick;
        addr_t target;
        test_name   = "recover mispredict";
        branch_nick = nick_t'(alloc_count % ROB_DEPTH);
        young_nick  = nick_t'((alloc_count + 1) % ROB_DEPTH);
        target      = 32'h0000_0400;
        drive_issue(5'd14, 1'b0, 1'b1, 1'b0);
        step_clock();
        drive_issue(5'd1, 1'b0, 1'b0, 1'b0);
        step_clock();
        drive_issue(5'd2, 1'b0, 1'b0, 1'b0);
        step_clock();
        // a younger result that the flush must discard
        drive_result(1'b0, young_nick, $urandom(), 1'b0, '0);
        check_reg(5'd1);
        step_clock();
        drive_result(1'b0, branch_nick, $urandom(), 1'b1, target);
        step_clock();
        check_value("full on mispredict", 32'd1, 32'(full));
        step_clock();
        retire_in_model(branch_nick);
        for (int i = 0; i < NREGS; i++) begin
            exp_busy[i] = 1'b0;
        end
        alloc_count = 0;
        check_reg(5'd1);
        check_reg(5'd2);
        check_reg(5'd14);
        check_value("full during redirect", 32'd1, 32'(full));
        while (!req) begin
            step_clock();
        end
        check_value("redirect pc", target, pc);
        check_value("full with req high", 32'd1, 32'(full));
        ack = 1'b1;
        step_clock();
        while (req) begin
            step_clock();
        end
        check_value("full until ack drops", 32'd1, 32'(full));
        ack = 1'b0;
        step_clock();
        while (full) begin
            step_clock();
        end
        check_true(!req, "req rose again after the handshake ended");
    endtask

    task automatic retire_good_branch();
        test_name = "retire good branch";
        drive_issue(5'd0, 1'b0, 1'b1, 1'b1);
        step_clock();
        drive_issue(5'd3, 1'b0, 1'b0, 1'b0);
        step_clock();
        drive_issue(5'd4, 1'b0, 1'b0, 1'b0);
        step_clock();
        drive_result(1'b0, 5'd0, '0, 1'b1, 32'h0000_0200);
        step_clock();
        drive_result(1'b0, 5'd1, $urandom(), 1'b0, '0);
        step_clock();
        retire_in_model(5'd0);
        check_true(!req, "redirect raised for a correctly predicted branch");
        check_value("full after good branch", 32'd0, 32'(full));
        drive_result(1'b0, 5'd2, $urandom(), 1'b0, '0);
        step_clock();
        retire_in_model(5'd1);
        check_true(!req, "redirect raised after a correctly predicted branch");
        step_clock();
        retire_in_model(5'd2);
        check_reg(5'd3);
        check_reg(5'd4);
        check_true(!req, "redirect raised while younger entries retired");
    endtask

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        issue       = '0;
        ex_result   = '0;
        slb_result  = '0;
        rs1         = '0;
        rs2         = '0;
        ack         = 1'b0;
        cycles      = 0;
        alloc_count = 0;
        test_name   = "reset";
        void'($urandom(16));
        for (int i = 0; i < NREGS; i++) begin
            exp_data[i] = '0;
            exp_busy[i] = 1'b0;
            exp_nick[i] = '0;
            ent_rd[i]   = '0;
            ent_data[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        reset = 1'b0;
        issue_in_order();
        complete_out_of_order();
        fill_to_capacity();
        retire_store();
        recover_mispredict();
        retire_good_branch();
        $display("NO ERRORS");
        $finish;
    end

endmodule

// ==== verilog/arch_pkg.sv ====
package arch_pkg;

    localparam int XLEN    = 32;
    localparam int NREGS   = 32;
    localparam int REGNM_W = 5;
    localparam int NICK_W  = 5;

    // architectural register name, x0 is hardwired
    typedef logic [REGNM_W-1:0] regnm_t;

    typedef logic [XLEN-1:0] data_t;

    typedef logic [XLEN-1:0] addr_t;

    // rename tag = rob entry index, room for 32 entries
    typedef logic [NICK_W-1:0] nick_t;

    // coarse instruction class as the rob sees it
    typedef logic [1:0] opclass_t;

    // alu ops and loads both write rd from a result
    localparam opclass_t OPC_ALU    = 2'd0;
    localparam opclass_t OPC_STORE  = 2'd1;
    localparam opclass_t OPC_BRANCH = 2'd2;

endpackage

// ==== verilog/redirect_port.sv ====
module redirect_port
    import arch_pkg::*, rob_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      start,
    input  redirect_t redirect,
    output logic      req,
    output addr_t     pc,
    input  logic      ack,
    output logic      busy
);

    typedef enum logic [1:0] {
        st_idle,
        st_raise,
        st_wait_low
    } state_t;

    state_t state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
            pc    <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        state <= st_raise;
                        pc    <= redirect.pc;
                    end
                end
                // hold req until fetch takes the pc
                st_raise: begin
                    if (ack) begin
                        state <= st_wait_low;
                    end
                end
                st_wait_low: begin
                    if (!ack) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    assign req  = (state == st_raise);
    // start cycle counts as busy so issue stays blocked
    assign busy = start || (state != st_idle);

    a_pc_stable: assert property (@(posedge clk) disable iff (reset)
        req |=> !req || $stable(pc));

endmodule

// ==== verilog/reg_file.sv ====
module reg_file
    import arch_pkg::*, rob_pkg::*;
#(
    parameter int ROB_DEPTH = 8
) (
    input  logic     clk,
    input  logic     reset,
    input  tag_set_t tag_set,
    input  commit_t  commit,
    input  logic     flush,
    input  regnm_t   rs1,
    input  regnm_t   rs2,
    output data_t    rs1_data,
    output data_t    rs2_data,
    output logic     rs1_busy,
    output logic     rs2_busy,
    output nick_t    rs1_nick,
    output nick_t    rs2_nick
);

    data_t             regs [NREGS];
    logic [NREGS-1:0]  busy;
    nick_t             tags [NREGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
            busy <= '0;
        end else begin
            if (commit.valid && (commit.rd != '0)) begin
                regs[commit.rd] <= commit.data;
                // only the newest producer releases the register
                if (tags[commit.rd] == commit.nick) begin
                    busy[commit.rd] <= 1'b0;
                end
            end
            if (flush) begin
                busy <= '0;
            end
            // a fresh rename beats a same-edge commit
            if (tag_set.valid && (tag_set.rd != '0)) begin
                busy[tag_set.rd] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tag_set.valid && (tag_set.rd != '0)) begin
            tags[tag_set.rd] <= tag_set.nick;
        end
    end

    // operand lookup, no bypass of the commit in flight
    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];
    assign rs1_busy = busy[rs1];
    assign rs2_busy = busy[rs2];
    assign rs1_nick = tags[rs1];
    assign rs2_nick = tags[rs2];

    // a rename of x0 is the only way x0 could turn busy
    a_x0_idle: assert property (@(posedge clk) disable iff (reset)
        tag_set.valid |-> (tag_set.rd != '0));

    a_tag_range: assert property (@(posedge clk) disable iff (reset)
        tag_set.valid |-> (int'(tag_set.nick) < ROB_DEPTH));

endmodule

// ==== verilog/rob.sv ====
module rob
    import arch_pkg::*, rob_pkg::*;
#(
    parameter int ROB_DEPTH = 8
) (
    input  logic          clk,
    input  logic          reset,
    input  issue_t        issue,
    output nick_t         nick,
    output logic          full,
    input  result_t       ex_result,
    input  result_t       slb_result,
    output tag_set_t      tag_set,
    output commit_t       commit,
    output store_commit_t store_commit,
    output logic          flush,
    output logic          redirect_start,
    output redirect_t     redirect,
    input  logic          redirect_busy
);

    localparam int PTR_W = $clog2(ROB_DEPTH);

    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [PTR_W:0]   count;

    // entry fields
    logic [ROB_DEPTH-1:0] done;
    regnm_t               rd_q     [ROB_DEPTH];
    data_t                data_q   [ROB_DEPTH];
    opclass_t             kind_q   [ROB_DEPTH];
    logic                 pred_q   [ROB_DEPTH];
    logic                 actual_q [ROB_DEPTH];
    addr_t                target_q [ROB_DEPTH];

    logic alloc;
    logic retire;
    logic mispredict;
    logic buf_full;

    // entry is live if it sits between head and tail
    function automatic logic occupied(nick_t n);
        logic [PTR_W-1:0] offset;
        offset = n[PTR_W-1:0] - head;
        return (int'(n) < ROB_DEPTH) && ((PTR_W+1)'(offset) < count);
    endfunction

    assign buf_full = (count == (PTR_W+1)'(ROB_DEPTH));

    // stall while the wrong path drains and the redirect is in flight
    assign full  = buf_full || mispredict || redirect_busy;
    assign alloc = issue.valid && !full;
    assign nick  = nick_t'(tail);

    assign tag_set.valid = alloc && !issue.is_store && (issue.rd != '0);
    assign tag_set.rd    = issue.rd;
    assign tag_set.nick  = nick;

    // stores retire without a result
    assign retire = (count != '0) && (done[head] || (kind_q[head] == OPC_STORE));
    assign mispredict = retire && (kind_q[head] == OPC_BRANCH) &&
                        (actual_q[head] != pred_q[head]);

    assign commit.valid = retire && (kind_q[head] != OPC_STORE);
    assign commit.nick  = nick_t'(head);
    assign commit.rd    = rd_q[head];
    assign commit.data  = data_q[head];

    assign store_commit.valid = retire && (kind_q[head] == OPC_STORE);
    assign store_commit.nick  = nick_t'(head);

    assign flush = mispredict;

    always_ff @(posedge clk) begin
        if (reset) begin
            head           <= '0;
            tail           <= '0;
            count          <= '0;
            done           <= '0;
            redirect_start <= 1'b0;
        end else begin
            redirect_start <= mispredict;
            if (mispredict) begin
                // everything younger than the branch is dropped
                head  <= '0;
                tail  <= '0;
                count <= '0;
                done  <= '0;
            end else begin
                if (alloc) begin
                    tail       <= tail + 1'b1;
                    done[tail] <= 1'b0;
                end
                if (retire) begin
                    head <= head + 1'b1;
                end
                count <= count + (PTR_W+1)'(alloc) - (PTR_W+1)'(retire);
                if (ex_result.valid) begin
                    done[ex_result.nick[PTR_W-1:0]] <= 1'b1;
                end
                if (slb_result.valid) begin
                    done[slb_result.nick[PTR_W-1:0]] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            rd_q[tail]   <= issue.rd;
            pred_q[tail] <= issue.pred_taken;
            if (issue.is_store) begin
                kind_q[tail] <= OPC_STORE;
            end else if (issue.is_branch) begin
                kind_q[tail] <= OPC_BRANCH;
            end else begin
                kind_q[tail] <= OPC_ALU;
            end
        end
        if (ex_result.valid) begin
            data_q[ex_result.nick[PTR_W-1:0]]   <= ex_result.data;
            actual_q[ex_result.nick[PTR_W-1:0]] <= ex_result.taken;
            target_q[ex_result.nick[PTR_W-1:0]] <= ex_result.target;
        end
        if (slb_result.valid) begin
            data_q[slb_result.nick[PTR_W-1:0]]   <= slb_result.data;
            actual_q[slb_result.nick[PTR_W-1:0]] <= slb_result.taken;
            target_q[slb_result.nick[PTR_W-1:0]] <= slb_result.target;
        end
        // corrected pc travels with the start pulse
        if (mispredict) begin
            redirect.pc <= target_q[head];
        end
    end

    a_ex_live: assert property (@(posedge clk) disable iff (reset)
        ex_result.valid |-> occupied(ex_result.nick));

    a_slb_live: assert property (@(posedge clk) disable iff (reset)
        slb_result.valid |-> occupied(slb_result.nick));

    // an accepted issue never overfills the buffer
    a_no_overfill: assert property (@(posedge clk) disable iff (reset)
        alloc |=> (count != '0) && (count <= (PTR_W+1)'(ROB_DEPTH)));

endmodule

// ==== verilog/rob_pkg.sv ====
package rob_pkg;

    import arch_pkg::*;

    // one instruction entering the rob
    typedef struct packed {
        logic   valid;
        regnm_t rd;
        logic   is_store;
        logic   is_branch;
        logic   pred_taken;
    } issue_t;

    // single-cycle completion from ex or the store/load buffer
    typedef struct packed {
        logic  valid;
        nick_t nick;
        data_t data;
        logic  taken;
        addr_t target;
    } result_t;

    // register file write on retirement
    typedef struct packed {
        logic   valid;
        nick_t  nick;
        regnm_t rd;
        data_t  data;
    } commit_t;

    // rename of rd at allocation
    typedef struct packed {
        logic   valid;
        regnm_t rd;
        nick_t  nick;
    } tag_set_t;

    typedef struct packed {
        logic  valid;
        nick_t nick;
    } store_commit_t;

    typedef struct packed {
        addr_t pc;
    } redirect_t;

endpackage

// ==== verilog/rob_top.sv ====
module rob_top
    import arch_pkg::*, rob_pkg::*;
#(
    parameter int ROB_DEPTH = 8
) (
    input  logic          clk,
    input  logic          reset,
    input  issue_t        issue,
    output nick_t         nick,
    output logic          full,
    input  result_t       ex_result,
    input  result_t       slb_result,
    output store_commit_t store_commit,
    input  regnm_t        rs1,
    input  regnm_t        rs2,
    output data_t         rs1_data,
    output logic          rs1_busy,
    output nick_t         rs1_nick,
    output data_t         rs2_data,
    output logic          rs2_busy,
    output nick_t         rs2_nick,
    output logic          req,
    output addr_t         pc,
    input  logic          ack
);

    tag_set_t  tag_set;
    commit_t   commit;
    logic      flush;
    logic      redirect_start;
    redirect_t redirect;
    logic      redirect_busy;

    rob #(
        .ROB_DEPTH (ROB_DEPTH)
    ) rob_i (
        .clk            (clk),
        .reset          (reset),
        .issue          (issue),
        .nick           (nick),
        .full           (full),
        .ex_result      (ex_result),
        .slb_result     (slb_result),
        .tag_set        (tag_set),
        .commit         (commit),
        .store_commit   (store_commit),
        .flush          (flush),
        .redirect_start (redirect_start),
        .redirect       (redirect),
        .redirect_busy  (redirect_busy)
    );

    reg_file #(
        .ROB_DEPTH (ROB_DEPTH)
    ) reg_file_i (
        .clk      (clk),
        .reset    (reset),
        .tag_set  (tag_set),
        .commit   (commit),
        .flush    (flush),
        .rs1      (rs1),
        .rs2      (rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .rs1_busy (rs1_busy),
        .rs2_busy (rs2_busy),
        .rs1_nick (rs1_nick),
        .rs2_nick (rs2_nick)
    );

    redirect_port redirect_port_i (
        .clk      (clk),
        .reset    (reset),
        .start    (redirect_start),
        .redirect (redirect),
        .req      (req),
        .pc       (pc),
        .ack      (ack),
        .busy     (redirect_busy)
    );

endmodule
